//--- Makefile
# rename core simulation with Verilator
# make compile | make run | make clean

VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, a crash without a pass line also fails
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "result: FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "result: FAIL, no pass line"; exit 1; fi
	@echo "result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/free_list.sv
// free list
// circular queue of free physical registers. reset fills it with the
// tags above the architectural range in order. the head is popped at
// dispatch and the old mapping of a retired entry joins the tail.
`timescale 1ns/10ps
`default_nettype none

module free_list (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       dispatch_take,
  input  wire                       retire_valid,
  input  wire rename_pkg::retire_t  retire,
  output rename_pkg::phys_reg_t     free_head
);

  rename_pkg::phys_reg_t fl_mem [rename_pkg::FREE_LIST_SIZE];
  rename_pkg::fl_ptr_t   head;
  rename_pkg::fl_ptr_t   tail;
  rename_pkg::fl_count_t count;

  logic pop;
  logic push;

  assign pop  = dispatch_take;
  assign push = retire_valid;

  // next free tag, valid whenever count is nonzero
  assign free_head = fl_mem[head];

  ////////////////////
  // storage
  ////////////////////
  // reset contents are part of the architectural start state
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::FREE_LIST_SIZE; i++) begin
        fl_mem[i] <= rename_pkg::phys_reg_t'(rename_pkg::NUM_ARCH_REGS + i);
      end
    end else if (push) begin
      fl_mem[tail] <= retire.phys_old;
    end
  end

  ////////////////////
  // pointers and count
  ////////////////////
  // pointers wrap on their own, size is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= rename_pkg::fl_count_t'(rename_pkg::FREE_LIST_SIZE);
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (push) begin
        tail <= tail + 1'b1;
      end
      case ({pop, push})
        2'b10:   count <= count - 1'b1;
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  // rob depth keeps at least 24 tags free, so these should never fire
  no_pop_when_empty : assert property (@(posedge clock) disable iff (reset)
    pop |-> count != '0);

  no_push_when_full : assert property (@(posedge clock) disable iff (reset)
    push |-> count != rename_pkg::fl_count_t'(rename_pkg::FREE_LIST_SIZE));

endmodule

`default_nettype wire

//--- logic/map_table.sv
// map table
// architectural to physical register map with a ready bit per entry.
// at dispatch it reads both sources and the old destination mapping,
// then installs the free list head as a new not ready mapping.
// completions set ready on any entry holding the finished tag.
// the rename result leaves through a one cycle output register.
`timescale 1ns/10ps
`default_nettype none

module map_table (
  input  wire                     clock,
  input  wire                     reset,
  input  wire                     dispatch_take,
  input  wire rename_pkg::rename_req_t dispatch,
  input  wire rename_pkg::phys_reg_t   free_head,
  input  wire                     complete_valid,
  input  wire rename_pkg::phys_reg_t   complete_tag,
  output logic                    renamed_valid,
  output rename_pkg::renamed_t    renamed
);

  // current mapping per arch reg
  rename_pkg::phys_reg_t map_tag   [rename_pkg::NUM_ARCH_REGS];
  logic                  map_ready [rename_pkg::NUM_ARCH_REGS];

  // rename result before the output register
  rename_pkg::renamed_t rename_next;

  ////////////////////
  // lookup
  ////////////////////
  // reads see the table as it stood before this edge,
  // so a same cycle completion or own dest write is not visible
  always_comb begin
    rename_next.phys_dest  = free_head;
    rename_next.phys_old   = map_tag[dispatch.arch_dest];
    rename_next.phys_src1  = map_tag[dispatch.arch_src1];
    rename_next.src1_ready = map_ready[dispatch.arch_src1];
    rename_next.phys_src2  = map_tag[dispatch.arch_src2];
    rename_next.src2_ready = map_ready[dispatch.arch_src2];
  end

  ////////////////////
  // table update
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, everything ready
      for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
        map_tag[r]   <= rename_pkg::phys_reg_t'(r);
        map_ready[r] <= 1'b1;
      end
    end else begin
      // broadcast match on the completed tag
      if (complete_valid) begin
        for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
          if (map_tag[r] == complete_tag) begin
            map_ready[r] <= 1'b1;
          end
        end
      end
      // new mapping wins over the broadcast for its own entry
      if (dispatch_take) begin
        map_tag[dispatch.arch_dest]   <= free_head;
        map_ready[dispatch.arch_dest] <= 1'b0;
      end
    end
  end

  ////////////////////
  // output register
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      renamed_valid <= 1'b0;
    end else begin
      renamed_valid <= dispatch_take;
    end
  end

  // payload only qualified by renamed_valid
  always_ff @(posedge clock) begin
    if (dispatch_take) begin
      renamed <= rename_next;
    end
  end

endmodule

`default_nettype wire

//--- logic/rename_core.sv
// rename core top level
// map table and free list rename each dispatched instruction, the
// reorder buffer tracks it until completion and retires in order.
// dispatch is accepted only while the reorder buffer has room.
`timescale 1ns/10ps
`default_nettype none

module rename_core (
  input  wire                          clock,
  input  wire                          reset,
  // dispatch side
  input  wire                          dispatch_valid,
  input  wire rename_pkg::rename_req_t dispatch,
  output logic                         dispatch_ready,
  // result broadcast
  input  wire                          complete_valid,
  input  wire rename_pkg::phys_reg_t   complete_tag,
  // rename and retire strobes
  output logic                         renamed_valid,
  output rename_pkg::renamed_t         renamed,
  output logic                         retire_valid,
  output rename_pkg::retire_t          retire
);

  logic                  dispatch_take;
  logic                  rob_full;
  rename_pkg::phys_reg_t free_head;

  ////////////////////
  // dispatch gate
  ////////////////////
  // free list never runs dry at these sizes, rob is the only hazard
  assign dispatch_ready = ~rob_full;
  assign dispatch_take  = dispatch_valid & dispatch_ready;

  map_table i_map_table (
    .clock          (clock),
    .reset          (reset),
    .dispatch_take  (dispatch_take),
    .dispatch       (dispatch),
    .free_head      (free_head),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .renamed_valid  (renamed_valid),
    .renamed        (renamed)
  );

  free_list i_free_list (
    .clock         (clock),
    .reset         (reset),
    .dispatch_take (dispatch_take),
    .retire_valid  (retire_valid),
    .retire        (retire),
    .free_head     (free_head)
  );

  reorder_buffer i_reorder_buffer (
    .clock          (clock),
    .reset          (reset),
    .dispatch_take  (dispatch_take),
    .arch_dest      (dispatch.arch_dest),
    .renamed_valid  (renamed_valid),
    .renamed        (renamed),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .rob_full       (rob_full),
    .retire_valid   (retire_valid),
    .retire         (retire)
  );

endmodule

`default_nettype wire

//--- logic/rename_pkg.sv
// rename core package
// sizes, tag types, port structs and reorder buffer entry states
// shared by the map table, free list, reorder buffer and top level
`default_nettype none

package rename_pkg;

  ////////////////////
  // sizes
  ////////////////////
  localparam int NUM_ARCH_REGS  = 32;
  localparam int NUM_PHYS_REGS  = 64;
  // every physical reg not holding an arch mapping at reset
  localparam int FREE_LIST_SIZE = NUM_PHYS_REGS - NUM_ARCH_REGS;
  localparam int ROB_SIZE       = 8;

  ////////////////////
  // index and tag types
  ////////////////////
  typedef logic [$clog2(NUM_ARCH_REGS)-1:0]  arch_reg_t;
  typedef logic [$clog2(NUM_PHYS_REGS)-1:0]  phys_reg_t;
  typedef logic [$clog2(ROB_SIZE)-1:0]       rob_ptr_t;
  // one extra bit so a full buffer is representable
  typedef logic [$clog2(ROB_SIZE):0]         rob_count_t;
  typedef logic [$clog2(FREE_LIST_SIZE)-1:0] fl_ptr_t;
  typedef logic [$clog2(FREE_LIST_SIZE):0]   fl_count_t;

  ////////////////////
  // port structs
  ////////////////////
  // decoded instruction registers at dispatch
  typedef struct packed {
    arch_reg_t arch_dest;
    arch_reg_t arch_src1;
    arch_reg_t arch_src2;
  } rename_req_t;

  // rename result, one cycle after dispatch
  typedef struct packed {
    phys_reg_t phys_dest;
    phys_reg_t phys_old;
    phys_reg_t phys_src1;
    logic      src1_ready;
    phys_reg_t phys_src2;
    logic      src2_ready;
  } renamed_t;

  // retired entry, phys_old goes back to the free list
  typedef struct packed {
    arch_reg_t arch_dest;
    phys_reg_t phys_dest;
    phys_reg_t phys_old;
  } retire_t;

  typedef enum logic [1:0] {
    EMPTY,
    WAITING,
    DONE
  } rob_state_e;

endpackage

`default_nettype wire

//--- logic/reorder_buffer.sv
// reorder buffer
// circular buffer of in-flight renames. a slot is reserved by the count
// at dispatch and written WAITING at the tail when the rename arrives.
// completions mark the matching entry DONE. a DONE head is retired into
// the output register, one entry per cycle in dispatch order.
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        dispatch_take,
  input  wire rename_pkg::arch_reg_t arch_dest,
  input  wire                        renamed_valid,
  input  wire rename_pkg::renamed_t  renamed,
  input  wire                        complete_valid,
  input  wire rename_pkg::phys_reg_t complete_tag,
  output logic                       rob_full,
  output logic                       retire_valid,
  output rename_pkg::retire_t        retire
);

  // entry fields
  rename_pkg::rob_state_e rob_state     [rename_pkg::ROB_SIZE];
  rename_pkg::arch_reg_t  rob_arch_dest [rename_pkg::ROB_SIZE];
  rename_pkg::phys_reg_t  rob_phys_dest [rename_pkg::ROB_SIZE];
  rename_pkg::phys_reg_t  rob_phys_old  [rename_pkg::ROB_SIZE];

  rename_pkg::rob_ptr_t   head;
  rename_pkg::rob_ptr_t   tail;
  rename_pkg::rob_count_t count;

  // arch dest lines up with the rename one cycle later
  rename_pkg::arch_reg_t  arch_dest_q;

  logic head_done;
  logic complete_hit;
  logic complete_bypass;

  assign rob_full  = (count == rename_pkg::rob_count_t'(rename_pkg::ROB_SIZE));
  assign head_done = (rob_state[head] == rename_pkg::DONE);

  // completion landing on the entry being written this edge
  assign complete_bypass = complete_valid && renamed_valid &&
                           (renamed.phys_dest == complete_tag);

  // does the completed tag belong to anything in flight
  always_comb begin
    complete_hit = complete_bypass;
    for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
      if (rob_state[i] != rename_pkg::EMPTY && rob_phys_dest[i] == complete_tag) begin
        complete_hit = 1'b1;
      end
    end
  end

  ////////////////////
  // entry state
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
        rob_state[i] <= rename_pkg::EMPTY;
      end
    end else begin
      // tags are unique among live entries
      if (complete_valid) begin
        for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
          if (rob_state[i] == rename_pkg::WAITING && rob_phys_dest[i] == complete_tag) begin
            rob_state[i] <= rename_pkg::DONE;
          end
        end
      end
      // tail slot was reserved at dispatch and is still EMPTY
      if (renamed_valid) begin
        rob_state[tail] <= complete_bypass ? rename_pkg::DONE : rename_pkg::WAITING;
      end
      if (head_done) begin
        rob_state[head] <= rename_pkg::EMPTY;
      end
    end
  end

  // payload fields
  always_ff @(posedge clock) begin
    if (dispatch_take) begin
      arch_dest_q <= arch_dest;
    end
    if (renamed_valid) begin
      rob_arch_dest[tail] <= arch_dest_q;
      rob_phys_dest[tail] <= renamed.phys_dest;
      rob_phys_old[tail]  <= renamed.phys_old;
    end
  end

  ////////////////////
  // pointers and count
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (renamed_valid) begin
        tail <= tail + 1'b1;
      end
      if (head_done) begin
        head <= head + 1'b1;
      end
      // reserve at dispatch and release on head pop
      case ({dispatch_take, head_done})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////
  // retire port
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= head_done;
    end
  end

  always_ff @(posedge clock) begin
    if (head_done) begin
      retire.arch_dest <= rob_arch_dest[head];
      retire.phys_dest <= rob_phys_dest[head];
      retire.phys_old  <= rob_phys_old[head];
    end
  end

  // the cdb stand-in only reports tags handed out by the map table
  complete_in_flight : assert property (@(posedge clock) disable iff (reset)
    complete_valid |-> complete_hit);

  // a new entry never lands on a live slot
  no_dispatch_when_full : assert property (@(posedge clock) disable iff (reset)
    renamed_valid |-> rob_state[tail] == rename_pkg::EMPTY);

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
// testbench clock and reset
// 10 ns clock, reset held high over the first four rising edges
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  // released just after the fourth rising edge
  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/rename_core_tb.sv
// rename core testbench
// directed table rows then a seeded random section, all checked against a
// model of the map, the free queue and in-order retirement
`timescale 1ns/10ps
`default_nettype none

module rename_core_tb;

  typedef struct packed {
    logic                    disp;
    rename_pkg::rename_req_t req;
    logic                    comp;
    rename_pkg::phys_reg_t   tag;
    logic [3:0]              idle;
  } row_t;

  // model reorder buffer entry
  typedef struct packed {
    rename_pkg::arch_reg_t arch_dest;
    rename_pkg::phys_reg_t phys_dest;
    rename_pkg::phys_reg_t phys_old;
    logic                  done;
  } rob_entry_t;

  logic                    clock;
  logic                    reset;
  logic                    dispatch_valid;
  logic                    dispatch_ready;
  logic                    complete_valid;
  logic                    renamed_valid;
  logic                    retire_valid;
  rename_pkg::rename_req_t dispatch;
  rename_pkg::phys_reg_t   complete_tag;
  rename_pkg::renamed_t    renamed;
  rename_pkg::retire_t     retire;

  ////////////////////
  // model state
  ////////////////////
  rename_pkg::phys_reg_t model_map   [rename_pkg::NUM_ARCH_REGS];
  logic                  model_ready [rename_pkg::NUM_ARCH_REGS];
  rename_pkg::phys_reg_t model_free  [$];
  rob_entry_t            model_rob   [$];
  rename_pkg::renamed_t  expected_rename;
  logic                  rename_pending;
  row_t                  table_rows  [$];
  rename_pkg::phys_reg_t open_tags   [$];
  int                    mismatch_count;
  int                    other_count;
  int                    timeout_count;
  int                    dispatch_count;
  int                    dropped_count;

  clock_gen i_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  rename_core i_rename_core (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .complete_valid (complete_valid),
    .complete_tag   (complete_tag),
    .renamed_valid  (renamed_valid),
    .renamed        (renamed),
    .retire_valid   (retire_valid),
    .retire         (retire)
  );

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, want);
      mismatch_count++;
    end
  endtask

  function automatic void add_row(input int disp, input int dest, input int src1,
                                  input int src2, input int comp, input int tag,
                                  input int idle);
    row_t row;
    row.disp          = (disp != 0);
    row.req.arch_dest = rename_pkg::arch_reg_t'(dest);
    row.req.arch_src1 = rename_pkg::arch_reg_t'(src1);
    row.req.arch_src2 = rename_pkg::arch_reg_t'(src2);
    row.comp          = (comp != 0);
    row.tag           = rename_pkg::phys_reg_t'(tag);
    row.idle          = 4'(idle);
    table_rows.push_back(row);
  endfunction

  ////////////////////
  // directed table
  ////////////////////
  function automatic void load_table();
    // quiet after reset
    add_row(0, 0, 0, 0, 0, 0, 2);
    // first rename gets 32 with identity sources ready
    add_row(1, 1, 2, 3, 0, 0, 0);
    // r1 read before its producer completes
    add_row(1, 4, 1, 5, 0, 0, 0);
    add_row(0, 0, 0, 0, 1, 32, 1);
    add_row(1, 6, 1, 4, 0, 0, 0);
    // same edge completion not seen by this reader
    add_row(1, 7, 4, 4, 1, 33, 0);
    add_row(1, 8, 4, 0, 0, 0, 0);
    // shuffled completions
    add_row(0, 0, 0, 0, 1, 35, 0);
    add_row(0, 0, 0, 0, 1, 34, 0);
    add_row(0, 0, 0, 0, 1, 36, 3);
    // r1 renamed again with old tag 32
    add_row(1, 1, 1, 1, 0, 0, 0);
    add_row(0, 0, 0, 0, 1, 37, 4);
    // fill the reorder buffer with tags 38 to 45
    for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
      add_row(1, 10 + i, i, 1, 0, 0, 0);
    end
    // offered while full so it is dropped
    add_row(1, 18, 0, 0, 0, 0, 0);
    add_row(0, 0, 0, 0, 1, 38, 2);
    add_row(1, 19, 10, 17, 0, 0, 0);
    for (int t = 39; t <= 46; t++) begin
      add_row(0, 0, 0, 0, 1, t, 0);
    end
  endfunction

  function automatic void collect_open_tags();
    open_tags.delete();
    foreach (model_rob[i]) begin
      if (!model_rob[i].done) begin
        open_tags.push_back(model_rob[i].phys_dest);
      end
    end
  endfunction

  // completion sets map ready bits and marks the rob entry
  function automatic void mark_complete(input rename_pkg::phys_reg_t tag);
    rob_entry_t entry;
    for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
      if (model_map[r] == tag) begin
        model_ready[r] = 1'b1;
      end
    end
    foreach (model_rob[i]) begin
      entry = model_rob[i];
      if (entry.phys_dest == tag) begin
        entry.done   = 1'b1;
        model_rob[i] = entry;
      end
    end
  endfunction

  // falling edge sample of outputs that moved at the rising edge
  task automatic observe_outputs();
    rob_entry_t head;
    @(negedge clock);
    compare_field("renamed_valid", 32'(renamed_valid), 32'(rename_pending));
    if (rename_pending && renamed_valid) begin
      compare_field("phys_dest", 32'(renamed.phys_dest), 32'(expected_rename.phys_dest));
      compare_field("phys_old", 32'(renamed.phys_old), 32'(expected_rename.phys_old));
      compare_field("phys_src1", 32'(renamed.phys_src1), 32'(expected_rename.phys_src1));
      compare_field("src1_ready", 32'(renamed.src1_ready), 32'(expected_rename.src1_ready));
      compare_field("phys_src2", 32'(renamed.phys_src2), 32'(expected_rename.phys_src2));
      compare_field("src2_ready", 32'(renamed.src2_ready), 32'(expected_rename.src2_ready));
    end
    rename_pending = 1'b0;
    if (retire_valid) begin
      if (model_rob.size() == 0) begin
        $display("ERROR at %0t: retire strobe with nothing in flight", $time);
        other_count++;
      end else begin
        head = model_rob.pop_front();
        if (!head.done) begin
          $display("ERROR at %0t: tag %0d retired before completing", $time, head.phys_dest);
          other_count++;
        end
        compare_field("retire.arch_dest", 32'(retire.arch_dest), 32'(head.arch_dest));
        compare_field("retire.phys_dest", 32'(retire.phys_dest), 32'(head.phys_dest));
        compare_field("retire.phys_old", 32'(retire.phys_old), 32'(head.phys_old));
        // freed tag joins the tail
        model_free.push_back(head.phys_old);
      end
    end
    compare_field("dispatch_ready", 32'(dispatch_ready),
                  32'(model_rob.size() < rename_pkg::ROB_SIZE));
  endtask

  task automatic drive_inputs(input row_t row);
    rob_entry_t entry;
    logic       take;
    take           = row.disp && (model_rob.size() < rename_pkg::ROB_SIZE);
    dispatch_valid = row.disp;
    dispatch       = row.req;
    complete_valid = 1'b0;
    complete_tag   = row.tag;
    if (row.disp && !take) begin
      dropped_count++;
    end
    // sources read before this edge's completion and own dest
    if (take) begin
      expected_rename.phys_dest  = model_free[0];
      expected_rename.phys_old   = model_map[row.req.arch_dest];
      expected_rename.phys_src1  = model_map[row.req.arch_src1];
      expected_rename.src1_ready = model_ready[row.req.arch_src1];
      expected_rename.phys_src2  = model_map[row.req.arch_src2];
      expected_rename.src2_ready = model_ready[row.req.arch_src2];
    end
    if (row.comp) begin
      collect_open_tags();
      if (row.tag inside {open_tags}) begin
        complete_valid = 1'b1;
        mark_complete(row.tag);
      end else begin
        $display("ERROR at %0t: completion tag %0d is not in flight", $time, row.tag);
        other_count++;
      end
    end
    // new mapping overrides the completion for its own entry
    if (take) begin
      model_free.delete(0);
      model_map[row.req.arch_dest]   = expected_rename.phys_dest;
      model_ready[row.req.arch_dest] = 1'b0;
      entry.arch_dest = row.req.arch_dest;
      entry.phys_dest = expected_rename.phys_dest;
      entry.phys_old  = expected_rename.phys_old;
      entry.done      = 1'b0;
      model_rob.push_back(entry);
      rename_pending = 1'b1;
      dispatch_count++;
    end
  endtask

  task automatic apply_row(input row_t row);
    observe_outputs();
    drive_inputs(row);
    for (int i = 0; i < int'(row.idle); i++) begin
      observe_outputs();
      drive_inputs('0);
    end
  endtask

  // idle until everything in flight has retired
  task automatic drain(input string section);
    int waited;
    waited = 0;
    while ((model_rob.size() != 0 || rename_pending) && waited < 100) begin
      observe_outputs();
      drive_inputs('0);
      waited++;
    end
    if (model_rob.size() != 0 || rename_pending) begin
      $display("TIMEOUT at %0t: %s section left %0d entries unretired", $time, section,
               model_rob.size());
      timeout_count++;
    end
  endtask

  ////////////////////
  // random section
  ////////////////////
  task automatic run_random();
    row_t row;
    int   start;
    int   steps;
    start = dispatch_count;
    steps = 0;
    while (dispatch_count - start < 60 && steps < 2000) begin
      collect_open_tags();
      row               = '0;
      row.disp          = ($urandom_range(3, 0) != 0);
      row.req.arch_dest = rename_pkg::arch_reg_t'($urandom_range(31, 0));
      row.req.arch_src1 = rename_pkg::arch_reg_t'($urandom_range(31, 0));
      row.req.arch_src2 = rename_pkg::arch_reg_t'($urandom_range(31, 0));
      // completion order picked at random among open tags
      if (open_tags.size() != 0 && $urandom_range(1, 0) == 1) begin
        row.comp = 1'b1;
        row.tag  = open_tags[$urandom_range(open_tags.size() - 1, 0)];
      end
      row.idle = 4'($urandom_range(2, 0));
      apply_row(row);
      steps++;
    end
    collect_open_tags();
    while (open_tags.size() != 0 && steps < 2000) begin
      row      = '0;
      row.comp = 1'b1;
      row.tag  = open_tags[$urandom_range(open_tags.size() - 1, 0)];
      row.idle = 4'($urandom_range(1, 0));
      apply_row(row);
      collect_open_tags();
      steps++;
    end
    if (steps >= 2000) begin
      $display("TIMEOUT at %0t: random section made no progress", $time);
      timeout_count++;
    end
  endtask

  initial begin
    int waited;
    void'($urandom(32'hed48));
    dispatch_valid = 1'b0;
    dispatch       = '0;
    complete_valid = 1'b0;
    complete_tag   = '0;
    rename_pending = 1'b0;
    mismatch_count = 0;
    other_count    = 0;
    timeout_count  = 0;
    dispatch_count = 0;
    dropped_count  = 0;
    // identity map with tags 32 to 63 free in order
    for (int r = 0; r < rename_pkg::NUM_ARCH_REGS; r++) begin
      model_map[r]   = rename_pkg::phys_reg_t'(r);
      model_ready[r] = 1'b1;
    end
    for (int t = rename_pkg::NUM_ARCH_REGS; t < rename_pkg::NUM_PHYS_REGS; t++) begin
      model_free.push_back(rename_pkg::phys_reg_t'(t));
    end
    load_table();
    waited = 0;
    while (reset !== 1'b0 && waited < 20) begin
      @(negedge clock);
      waited++;
    end
    if (reset !== 1'b0) begin
      $display("TIMEOUT at %0t: reset never released", $time);
      timeout_count++;
    end else begin
      foreach (table_rows[i]) begin
        apply_row(table_rows[i]);
      end
      drain("directed");
      if (timeout_count == 0) begin
        run_random();
      end
      if (timeout_count == 0) begin
        drain("random");
      end
    end
    if (dropped_count == 0) begin
      $display("ERROR: no dispatch was ever offered against a full reorder buffer");
      other_count++;
    end
    $display("errors: %0d mismatches, %0d other, %0d timeouts (%0d dispatches)",
             mismatch_count, other_count, timeout_count, dispatch_count);
    if (mismatch_count == 0 && other_count == 0 && timeout_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/rename_pkg.sv
logic/map_table.sv
logic/free_list.sv
logic/reorder_buffer.sv
logic/rename_core.sv
sim/clock_gen.sv
sim/rename_core_tb.sv
